// File: logic/board_pkg.sv
package board_pkg;

    //------------------------------------------------------------------
    // Screen and colour

    localparam int screen_width  = 800;
    localparam int screen_height = 480;

    localparam int w_x     = 10;  // Enough for 0 to 799
    localparam int w_y     = 9;   // Enough for 0 to 479

    localparam int w_red   = 5;
    localparam int w_green = 6;
    localparam int w_blue  = 5;

    //------------------------------------------------------------------
    // Lab inputs and outputs

    localparam int w_key = 4;
    localparam int w_sw  = 4;
    localparam int w_led = 6;

    //------------------------------------------------------------------
    // LCD timing in pixel clocks and lines

    localparam int h_front = 40;
    localparam int h_sync  = 48;
    localparam int h_back  = 88;

    localparam int v_front = 13;
    localparam int v_sync  = 3;
    localparam int v_back  = 29;

    localparam int h_total = screen_width  + h_front + h_sync + h_back;  // 976
    localparam int v_total = screen_height + v_front + v_sync + v_back;  // 525

    localparam int w_h_cnt = $clog2(h_total);
    localparam int w_v_cnt = $clog2(v_total);

    //------------------------------------------------------------------
    // Audio

    localparam int w_sound           = 16;
    localparam int slots_per_channel = 32;
    localparam int bclk_divide       = 4;   // Clocks per bclk half period

    localparam int w_slot     = $clog2(slots_per_channel);
    localparam int w_bclk_cnt = (bclk_divide > 1) ? $clog2(bclk_divide) : 1;

    localparam logic [15:0] tone_amplitude = 16'h2000;
    localparam int          tone_step      = 64;

    // Longest half period is eight switch units
    localparam int w_tone_cnt = $clog2(8 * tone_step);

endpackage

// File: logic/slow_clk_gen.sv
`timescale 1ns/10ps

module slow_clk_gen
    import board_pkg::*;
#(
    parameter int clk_mhz     = 27,
    parameter int slow_clk_hz = 1
)
(
    input  logic clk,
    input  logic rst,
    output logic slow_tick
);

    localparam int period = clk_mhz * 1000000 / slow_clk_hz;
    localparam int w_cnt  = (period > 1) ? $clog2(period) : 1;

    logic [w_cnt - 1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt       <= '0;
            slow_tick <= 1'b0;
        end
        else if (cnt == w_cnt'(period - 1))
        begin
            cnt       <= '0;
            slow_tick <= 1'b1;  // One cycle strobe
        end
        else
        begin
            cnt       <= cnt + 1'b1;
            slow_tick <= 1'b0;
        end
    end

endmodule

// File: logic/lcd_800_480.sv
`timescale 1ns/10ps

module lcd_800_480
    import board_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    output logic             lcd_de,
    output logic             lcd_hs,
    output logic             lcd_vs,
    output logic [w_x - 1:0] x,
    output logic [w_y - 1:0] y
);

    // Counters hold the position that goes out on the next clock
    logic [w_h_cnt - 1:0] h_cnt;
    logic [w_v_cnt - 1:0] v_cnt;

    logic h_active;
    logic v_active;
    logic h_sync_zone;
    logic v_sync_zone;
    logic h_last;
    logic v_last;

    assign h_active = h_cnt < w_h_cnt'(screen_width);
    assign v_active = v_cnt < w_v_cnt'(screen_height);

    assign h_sync_zone = (h_cnt >= w_h_cnt'(screen_width + h_front))
                      && (h_cnt <  w_h_cnt'(screen_width + h_front + h_sync));

    assign v_sync_zone = (v_cnt >= w_v_cnt'(screen_height + v_front))
                      && (v_cnt <  w_v_cnt'(screen_height + v_front + v_sync));

    assign h_last = h_cnt == w_h_cnt'(h_total - 1);
    assign v_last = v_cnt == w_v_cnt'(v_total - 1);

    //------------------------------------------------------------------
    // Registered panel outputs

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            lcd_de <= 1'b0;
            lcd_hs <= 1'b1;
            lcd_vs <= 1'b1;
            x      <= '0;
            y      <= '0;
        end
        else
        begin
            lcd_de <= h_active & v_active;
            lcd_hs <= ~h_sync_zone;       // Active low
            lcd_vs <= ~v_sync_zone;
            x      <= w_x'(h_cnt);
            y      <= w_y'(v_cnt);
        end
    end

    //------------------------------------------------------------------
    // Free-running position counters

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else if (h_last)
        begin
            h_cnt <= '0;
            v_cnt <= v_last ? '0 : v_cnt + 1'b1;
        end
        else
        begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

endmodule

// File: logic/lab_top.sv
`timescale 1ns/10ps

module lab_top
    import board_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 slow_tick,

    input  logic [w_key   - 1:0] key,
    input  logic [w_sw    - 1:0] sw,

    input  logic [w_x     - 1:0] x,
    input  logic [w_y     - 1:0] y,

    output logic [w_led   - 1:0] led,

    output logic [w_red   - 1:0] red,
    output logic [w_green - 1:0] green,
    output logic [w_blue  - 1:0] blue,

    output logic [w_sound - 1:0] sound
);

    //------------------------------------------------------------------
    // Up/down counter on the LEDs

    logic [w_led - 1:0] led_cnt;

    always_ff @(posedge clk)
    begin
        if (rst)
            led_cnt <= '0;
        else if (key[0])
            led_cnt <= '0;              // Held key clears the count
        else if (slow_tick)
        begin
            if (sw[0])
                led_cnt <= led_cnt - 1'b1;
            else
                led_cnt <= led_cnt + 1'b1;
        end
    end

    assign led = led_cnt;

    //------------------------------------------------------------------
    // Colour pattern

    // Coarse gradients from the upper coordinate bits
    assign red   = x[w_x - 1 -: w_red];
    assign green = y[w_y - 1 -: w_green];
    assign blue  = key[1] ? '1 : '0;

    //------------------------------------------------------------------
    // Square tone

    logic [w_tone_cnt - 1:0] tone_cnt;
    logic [w_tone_cnt - 1:0] tone_limit;
    logic                    tone_neg;

    // Half period is (sw[3:1] + 1) steps
    assign tone_limit = w_tone_cnt'((int'(sw[3:1]) + 1) * tone_step - 1);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tone_cnt <= '0;
            tone_neg <= 1'b0;
        end
        else if (tone_cnt >= tone_limit)  // Also catches a lowered limit
        begin
            tone_cnt <= '0;
            tone_neg <= ~tone_neg;
        end
        else
        begin
            tone_cnt <= tone_cnt + 1'b1;
        end
    end

    assign sound = tone_neg ? w_sound'(0) - tone_amplitude : tone_amplitude;

endmodule

// File: logic/i2s_audio_out.sv
`timescale 1ns/10ps

module i2s_audio_out
    import board_pkg::*;
#(
    parameter bit align_right         = 1'b0,
    parameter bit offset_by_one_cycle = 1'b0
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [w_sound - 1:0] data_in,
    output logic                 mclk,
    output logic                 bclk,
    output logic                 lrclk,
    output logic                 sdata
);

    // Slot that carries the MSB inside each half-frame
    localparam int first_slot = align_right ? slots_per_channel - w_sound
                                            : (offset_by_one_cycle ? 1 : 0);

    logic [w_bclk_cnt - 1:0] div_cnt;
    logic [w_slot     - 1:0] slot;
    logic [w_slot     - 1:0] next_slot;
    logic [w_sound    - 1:0] shift;
    logic [w_sound    - 1:0] word;

    logic bclk_toggle;
    logic bclk_fall;
    logic frame_start;
    logic in_window;

    //------------------------------------------------------------------
    // Master and bit clocks

    always_ff @(posedge clk)
    begin
        if (rst)
            mclk <= 1'b0;
        else
            mclk <= ~mclk;              // clk / 2
    end

    assign bclk_toggle = div_cnt == w_bclk_cnt'(bclk_divide - 1);
    assign bclk_fall   = bclk_toggle & bclk;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            bclk    <= 1'b0;
        end
        else if (bclk_toggle)
        begin
            div_cnt <= '0;
            bclk    <= ~bclk;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    //------------------------------------------------------------------
    // Slots, word select and serial data

    assign next_slot = (slot == w_slot'(slots_per_channel - 1)) ? '0 : slot + 1'b1;
    assign frame_start = next_slot == '0;

    assign in_window = (int'(next_slot) >= first_slot)
                    && (int'(next_slot) <  first_slot + w_sound);

    // New sample is taken at the word select edge
    assign word = frame_start ? data_in : shift;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            slot  <= '0;
            lrclk <= 1'b0;
            sdata <= 1'b0;
            shift <= '0;
        end
        else if (bclk_fall)               // Everything moves on the falling bclk edge
        begin
            slot <= next_slot;

            if (frame_start)
                lrclk <= ~lrclk;

            if (in_window)
            begin
                sdata <= word[w_sound - 1];             // MSB first
                shift <= {word[w_sound - 2:0], 1'b0};
            end
            else
            begin
                sdata <= 1'b0;                          // Unused slots
                shift <= word;
            end
        end
    end

endmodule

// File: logic/board_specific_top.sv
`timescale 1ns/10ps

module board_specific_top
    import board_pkg::*;
#(
    parameter int clk_mhz     = 27,
    parameter int slow_clk_hz = 1
)
(
    input  logic                 clk,
    input  logic                 rst,

    input  logic [w_key   - 1:0] key_n,
    input  logic [w_sw    - 1:0] sw_n,

    output logic [w_led   - 1:0] led_n,

    output logic                 lcd_de,
    output logic                 lcd_vs,
    output logic                 lcd_hs,
    output logic                 lcd_bl,

    output logic [w_red   - 1:0] lcd_r,
    output logic [w_green - 1:0] lcd_g,
    output logic [w_blue  - 1:0] lcd_b,

    output logic                 pa_en,
    output logic                 hp_din,
    output logic                 hp_ws,
    output logic                 hp_bck,

    output logic                 sck,
    output logic                 bck,
    output logic                 lrck,
    output logic                 din
);

    logic [w_key   - 1:0] key;
    logic [w_sw    - 1:0] sw;
    logic [w_led   - 1:0] led;
    logic [w_x     - 1:0] x;
    logic [w_y     - 1:0] y;
    logic [w_sound - 1:0] sound;
    logic                 slow_tick;

    //------------------------------------------------------------------
    // Board pin polarity

    assign key    = ~key_n;               // Keys and switches are active low
    assign sw     = ~sw_n;
    assign led_n  = ~led;

    assign lcd_bl = ~rst;
    assign pa_en  = 1'b1;                 // PT8211 amplifier always on

    //------------------------------------------------------------------

    slow_clk_gen #(
        .clk_mhz     ( clk_mhz     ),
        .slow_clk_hz ( slow_clk_hz )
    ) i_slow_clk_gen (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .slow_tick ( slow_tick )
    );

    lcd_800_480 i_lcd (
        .clk    ( clk    ),
        .rst    ( rst    ),
        .lcd_de ( lcd_de ),
        .lcd_hs ( lcd_hs ),
        .lcd_vs ( lcd_vs ),
        .x      ( x      ),
        .y      ( y      )
    );

    lab_top i_lab_top (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .slow_tick ( slow_tick ),
        .key       ( key       ),
        .sw        ( sw        ),
        .x         ( x         ),
        .y         ( y         ),
        .led       ( led       ),
        .red       ( lcd_r     ),
        .green     ( lcd_g     ),
        .blue      ( lcd_b     ),
        .sound     ( sound     )
    );

    //------------------------------------------------------------------
    // Audio outputs

    // On-board PT8211 wants the LSB at the end of the half-frame
    i2s_audio_out #(
        .align_right         ( 1'b1 ),
        .offset_by_one_cycle ( 1'b0 )
    ) i_hp_audio_out (
        .clk     ( clk    ),
        .rst     ( rst    ),
        .data_in ( sound  ),
        .mclk    (        ),          // PT8211 has no master clock
        .bclk    ( hp_bck ),
        .lrclk   ( hp_ws  ),
        .sdata   ( hp_din )
    );

    // External PCM5102A in standard I2S form
    i2s_audio_out #(
        .align_right         ( 1'b0 ),
        .offset_by_one_cycle ( 1'b1 )
    ) i_ext_audio_out (
        .clk     ( clk   ),
        .rst     ( rst   ),
        .data_in ( sound ),
        .mclk    ( sck   ),
        .bclk    ( bck   ),
        .lrclk   ( lrck  ),
        .sdata   ( din   )
    );

endmodule

// File: bench/tb_board_assert.sv
`timescale 1ns/10ps

module tb_board_assert
    import board_pkg::*;
(
    input logic             clk,
    input logic             rst,
    input logic             de,
    input logic             hs,
    input logic             vs,
    input logic [w_x - 1:0] x,
    input logic             bclk,
    input logic             lrclk
);

    int fail_count = 0;  // Read by the testbench top

    //----------------------------------------------------------------------
    // LCD timing

    // Syncs only in the blanking interval
    de_outside_sync: assert property (@(posedge clk) disable iff (rst)
        de |-> (hs && vs))
        else
        begin
            $error("DE high while a sync is low");
            fail_count++;
        end

    x_steps_by_one: assert property (@(posedge clk) disable iff (rst)
        (de && $past(de)) |-> (x == $past(x) + 1'b1))
        else
        begin
            $error("x did not advance by one during DE");
            fail_count++;
        end

    //----------------------------------------------------------------------
    // I2S framing

    lrclk_on_bclk_fall: assert property (@(posedge clk) disable iff (rst)
        $changed(lrclk) |-> $fell(bclk))
        else
        begin
            $error("Word select changed away from a falling bit clock");
            fail_count++;
        end

endmodule

bind lcd_800_480 tb_board_assert lcd_checks (
    .clk   ( clk    ),
    .rst   ( rst    ),
    .de    ( lcd_de ),
    .hs    ( lcd_hs ),
    .vs    ( lcd_vs ),
    .x     ( x      ),
    .bclk  ( 1'b0   ),
    .lrclk ( 1'b0   )
);

bind i2s_audio_out tb_board_assert i2s_checks (
    .clk   ( clk   ),
    .rst   ( rst   ),
    .de    ( 1'b0  ),
    .hs    ( 1'b1  ),
    .vs    ( 1'b1  ),
    .x     ( '0    ),
    .bclk  ( bclk  ),
    .lrclk ( lrclk )
);

// File: bench/tb_board.sv
`timescale 1ns/10ps

module tb_board
    import board_pkg::*;
;

    localparam int tb_clk_mhz     = 1;
    localparam int tb_slow_hz     = 100000;
    localparam int slow_period    = tb_clk_mhz * 1000000 / tb_slow_hz;  // 10 cycles
    localparam int reset_cycles   = 3;
    localparam int run_cycles     = h_total * v_total + 2000;           // One frame and a bit
    localparam int timeout_cycles = run_cycles * 12 / 10;
    localparam int stim_interval  = 50;

    localparam logic [w_sound - 1:0] neg_amplitude = ~tone_amplitude + 16'd1;

    logic                 clk;
    logic                 rst;
    logic [w_key   - 1:0] key_n;
    logic [w_sw    - 1:0] sw_n;
    logic [w_led   - 1:0] led_n;
    logic                 lcd_de, lcd_vs, lcd_hs, lcd_bl;
    logic [w_red   - 1:0] lcd_r;
    logic [w_green - 1:0] lcd_g;
    logic [w_blue  - 1:0] lcd_b;
    logic                 pa_en, hp_din, hp_ws, hp_bck;
    logic                 sck, bck, lrck, din;

    board_specific_top #(
        .clk_mhz     ( tb_clk_mhz ),
        .slow_clk_hz ( tb_slow_hz )
    ) dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //----------------------------------------------------------------------
    // Reference models, stepped on the rising edge

    int                 nh, nv;     // Pixel that goes out on the next clock
    int                 m_x, m_y;
    logic               m_de, m_hs, m_vs, m_sck, m_tick;
    logic               m_bck, m_ws;
    logic [w_led - 1:0] m_led;
    int                 tick_cnt;
    int                 bck_cnt, fall_cnt;

    always @(posedge clk)
    begin
        if (rst)
        begin
            nh       = 0;
            nv       = 0;
            m_x      = 0;
            m_y      = 0;
            m_de     = 1'b0;
            m_hs     = 1'b1;
            m_vs     = 1'b1;
            m_led    = '0;
            m_tick   = 1'b0;
            tick_cnt = 0;
            m_sck    = 1'b0;
            m_bck    = 1'b0;
            m_ws     = 1'b0;
            bck_cnt  = 0;
            fall_cnt = 0;
        end
        else
        begin
            m_de = (nh < screen_width) && (nv < screen_height);
            m_hs = !((nh >= screen_width + h_front) && (nh < screen_width + h_front + h_sync));
            m_vs = !((nv >= screen_height + v_front)
                  && (nv < screen_height + v_front + v_sync));
            m_x  = nh;
            m_y  = nv;
            nh   = nh + 1;
            if (nh == h_total)
            begin
                nh = 0;
                nv = (nv + 1) % v_total;
            end

            if (!key_n[0])
                m_led = '0;                          // Clear wins over counting
            else if (m_tick)
                m_led = sw_n[0] ? m_led + 1'b1 : m_led - 1'b1;  // sw[0] low counts up

            tick_cnt = tick_cnt + 1;
            m_tick   = (tick_cnt == slow_period);
            if (m_tick)
                tick_cnt = 0;

            m_sck = ~m_sck;

            // Word select flips on every 32nd falling bit clock
            bck_cnt = bck_cnt + 1;
            if (bck_cnt == bclk_divide)
            begin
                bck_cnt = 0;
                if (m_bck)
                    fall_cnt = fall_cnt + 1;
                if (m_bck && fall_cnt == slots_per_channel)
                begin
                    fall_cnt = 0;
                    m_ws     = ~m_ws;
                end
                m_bck = ~m_bck;
            end
        end
    end

    //----------------------------------------------------------------------
    // Failure reporting and compare tasks

    task automatic fail_and_stop();
        $display("Regression failed");
        $fatal(1, "Run stopped on a failed check");
    endtask

    task automatic check_led(input string name, input logic [w_led - 1:0] expected,
                             input logic [w_led - 1:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            fail_and_stop();
        end
    endtask

    task automatic check_colour(input string name,
                                input logic [w_red - 1:0] exp_r,
                                input logic [w_green - 1:0] exp_g,
                                input logic [w_blue - 1:0] exp_b,
                                input logic [w_red - 1:0] act_r,
                                input logic [w_green - 1:0] act_g,
                                input logic [w_blue - 1:0] act_b);
        if ({act_r, act_g, act_b} !== {exp_r, exp_g, exp_b})
        begin
            $display("[ERROR] %s: expected %h %h %h, actual %h %h %h",
                     name, exp_r, exp_g, exp_b, act_r, act_g, act_b);
            fail_and_stop();
        end
    endtask

    task automatic check_sample(input string name, input logic [w_sound - 1:0] expected,
                                input logic [w_sound - 1:0] actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            fail_and_stop();
        end
    endtask

    task automatic check_sync(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
            fail_and_stop();
        end
    endtask

    //----------------------------------------------------------------------
    // Serial audio decoding

    logic        prev_bck, prev_ws, have_edge;
    int          slot_idx, pos_words, neg_words;
    logic [31:0] hp_frame, ext_frame;  // Bit n is slot n

    task automatic decode_half_frame();
        logic [w_sound - 1:0] hp_word, hp_lead, ext_word, ext_unused;
        int                   i;

        if (slot_idx != slots_per_channel)
        begin
            $display("Half-frame had %0d bit-clock periods instead of %0d",
                     slot_idx, slots_per_channel);
            fail_and_stop();
        end
        for (i = 0; i < w_sound; i++)
        begin
            hp_word[w_sound - 1 - i]  = hp_frame[slots_per_channel - w_sound + i];
            hp_lead[w_sound - 1 - i]  = hp_frame[i];
            ext_word[w_sound - 1 - i] = ext_frame[1 + i];
        end
        ext_unused[15] = ext_frame[0];
        for (i = 17; i < 32; i++)
            ext_unused[31 - i] = ext_frame[i];

        if (hp_word == neg_amplitude)
            neg_words++;
        else
        begin
            check_sample("hp_din word", tone_amplitude, hp_word);
            pos_words++;
        end
        check_sample("hp_din leading slots", '0, hp_lead);
        check_sample("din word", hp_word, ext_word);   // Same half-frame on both DACs
        check_sample("din unused slots", '0, ext_unused);
    endtask

    task automatic compare_outputs();
        logic [w_x - 1:0]    xv;
        logic [w_y - 1:0]    yv;
        logic [w_blue - 1:0] exp_b;

        if (rst)
            check_led("led during reset", '1, led_n);  // All LEDs off
        else
            check_led("led count", ~m_led, led_n);

        check_sync("lcd_de", m_de, lcd_de);
        check_sync("lcd_hs", m_hs, lcd_hs);
        check_sync("lcd_vs", m_vs, lcd_vs);
        check_sync("lcd_bl", rst ? 1'b0 : 1'b1, lcd_bl);
        check_sync("pa_en", 1'b1, pa_en);
        check_sync("sck", m_sck, sck);
        check_sync("hp_bck", m_bck, hp_bck);
        check_sync("hp_ws", m_ws, hp_ws);
        check_sync("bck", m_bck, bck);
        check_sync("lrck", m_ws, lrck);

        if (m_de)
        begin
            xv    = w_x'(m_x);
            yv    = w_y'(m_y);
            exp_b = key_n[1] ? '0 : '1;
            check_colour("pixel colour", xv[9:5], yv[8:3], exp_b, lcd_r, lcd_g, lcd_b);
        end

        if (hp_ws !== prev_ws)
        begin
            if (have_edge)
                decode_half_frame();
            have_edge = 1'b1;
            slot_idx  = 0;
            hp_frame  = '0;
            ext_frame = '0;
        end
        if (hp_bck && !prev_bck)               // Data is stable at the rising bit clock
        begin
            if (slot_idx < 32)
            begin
                hp_frame[slot_idx]  = hp_din;
                ext_frame[slot_idx] = din;
            end
            slot_idx++;
        end
        prev_ws  = hp_ws;
        prev_bck = hp_bck;

        if (dut.i_lcd.lcd_checks.fail_count != 0
            || dut.i_hp_audio_out.i2s_checks.fail_count != 0
            || dut.i_ext_audio_out.i2s_checks.fail_count != 0)
        begin
            $display("A bound assertion reported a failure");
            fail_and_stop();
        end
    endtask

    //----------------------------------------------------------------------
    // Random stimulus

    logic [15:0] lfsr;

    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return (state >> 1) ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] value);
        int i;

        value = '0;
        for (i = 0; i < n; i++)
        begin
            value = {value[6:0], lfsr[0]};
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    task automatic drive_new_inputs();
        logic [7:0] r0, r1, r2;

        take_bits(3, r0);
        take_bits(3, r1);
        take_bits(4, r2);
        key_n = ~{r1[2:0], (r0[2:0] == 3'b111)};  // key[0] about one time in eight
        sw_n  = ~r2[3:0];
    endtask

    int cycle_count;

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= timeout_cycles)
        begin
            $display("Timeout: the run did not end within %0d clock cycles", timeout_cycles);
            fail_and_stop();
        end
    end

    initial
    begin
        rst         = 1'b1;
        key_n       = '1;
        sw_n        = '1;
        lfsr        = 16'd68;
        cycle_count = 0;
        prev_bck    = 1'b0;
        prev_ws     = 1'b0;
        have_edge   = 1'b0;
        slot_idx    = 0;
        pos_words   = 0;
        neg_words   = 0;
        hp_frame    = '0;
        ext_frame   = '0;

        for (int n = 0; n < run_cycles + reset_cycles; n++)
        begin
            @(negedge clk);
            compare_outputs();
            if (n == reset_cycles - 1)
                rst = 1'b0;
            if (!rst && ((n - (reset_cycles - 1)) % stim_interval == 0))
                drive_new_inputs();
        end

        if (pos_words > 0 && neg_words > 0)
        begin
            $display("Regression passed");
            $finish;
        end
        else
        begin
            $display("Tone words did not show both signs (%0d positive, %0d negative)",
                     pos_words, neg_words);
            fail_and_stop();
        end
    end

endmodule

// File: board_lab.f
logic/board_pkg.sv
logic/slow_clk_gen.sv
logic/lcd_800_480.sv
logic/lab_top.sv
logic/i2s_audio_out.sv
logic/board_specific_top.sv
bench/tb_board_assert.sv
bench/tb_board.sv
